// ==== src/hacd_cfg.svh ====
/*
 * Sizes and base addresses of the memory core.
 * Address and data are assumed to be the same width, 32 bits.
 * HACD_NUM_PAGES must equal 2**HACD_LPN_W.
 * Only the page-index field above HACD_PAGE_SHIFT is translated.
 */
`ifndef HACD_CFG_SVH
`define HACD_CFG_SVH

// bus widths
`define HACD_ADDR_W      32
`define HACD_DATA_W      32

// page geometry
`define HACD_PAGE_SHIFT  12                     // 4 KiB pages
`define HACD_NUM_PAGES   16                     // att entries, free-list length
`define HACD_LPN_W       4                      // page index bits

// address map
`define HACD_DRAM_BASE   32'h8000_0000          // board offset of dram
`define HACD_LIST_BASE   32'h0001_0000          // free list byte address
`define HACD_LIST_NULL   {`HACD_DATA_W{1'b1}}   // end of list marker

`endif

// ==== src/hacd_pkg.sv ====
/*
 * Types shared by the memory core and its testbench.
 * Requests carry a single beat, with no burst or side-band fields.
 */
`default_nettype none

`include "hacd_cfg.svh"

package hacd_pkg;

   //////////////////////////////
   // memory port payloads
   //////////////////////////////

   typedef struct packed {
      logic                    wr;     // 1 write, 0 read
      logic [`HACD_ADDR_W-1:0] addr;   // byte address
      logic [`HACD_DATA_W-1:0] wdata;  // ignored on reads
   } mem_req_t;

   typedef struct packed {
      logic [`HACD_DATA_W-1:0] rdata;  // don't care on writes
      logic                    err;    // slave error
   } mem_rsp_t;

   //////////////////////////////
   // internal control payloads
   //////////////////////////////

   typedef struct packed {
      logic                   en;      // write strobe
      logic [`HACD_LPN_W-1:0] idx;     // logical page
      logic [`HACD_LPN_W-1:0] ppn;     // physical page
   } att_wr_t;

   typedef struct packed {
      logic allow_access;              // cpu may issue
      logic translate;                 // use att lookup
   } cpu_ovrd_t;

   // control unit states
   typedef enum logic [1:0] {
      IDLE,                            // waiting for active
      INIT_ATT,                        // filling the table
      INIT_LIST,                       // free list being written
      ACTIVE                           // translating cpu traffic
   } hawk_state_e;

endpackage

`default_nettype wire

// ==== src/hawk_ctrl_unit.sv ====
/*
 * Reset-time sequencer: fills the ATT, then has the free list written.
 * Logical page i maps to physical page HACD_NUM_PAGES-1-i.
 * ACTIVE is left only by reset.
 */
`timescale 1ns/100ps
`default_nettype none

`include "hacd_cfg.svh"

module hawk_ctrl_unit
   import hacd_pkg::*;
(
   input  wire       clk_i,
   input  wire       arst_n_i,
   input  wire       hawk_inactive_i,
   input  wire       list_ack_i,    // from list writer
   output logic      list_req_o,    // four-phase request
   output att_wr_t   att_wr_o,
   output cpu_ovrd_t cpu_ovrd_o,
   output logic      init_done_o
);

   hawk_state_e            state_q;
   logic [`HACD_LPN_W-1:0] cnt_q;       // table entry index
   logic                   list_req_q;
   logic [31:0]            cnt_ext;
   logic [31:0]            ppn_full;
   logic                   last_entry;

   assign cnt_ext    = {{(32-`HACD_LPN_W){1'b0}}, cnt_q};
   assign last_entry = (cnt_ext == `HACD_NUM_PAGES - 1);
   assign ppn_full   = `HACD_NUM_PAGES - 1 - cnt_ext;   // reversed mapping

   //////////////////////////////
   // sequencer
   //////////////////////////////

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= IDLE;
         cnt_q      <= '0;
         list_req_q <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (!hawk_inactive_i) begin
                  state_q <= INIT_ATT;
                  cnt_q   <= '0;
               end
            end
            INIT_ATT: begin
               cnt_q <= cnt_q + 1'b1;            // one entry per cycle
               if (last_entry) begin
                  state_q    <= INIT_LIST;
                  list_req_q <= 1'b1;            // raise req after last entry
               end
            end
            INIT_LIST: begin
               if (list_ack_i) begin
                  list_req_q <= 1'b0;            // phase 3
               end else if (!list_req_q) begin
                  state_q <= ACTIVE;             // ack has fallen
               end
            end
            default: begin
               state_q <= state_q;               // active holds until reset
            end
         endcase
      end
   end

   //////////////////////////////
   // outputs
   //////////////////////////////

   always_comb begin
      att_wr_o.en  = (state_q == INIT_ATT);
      att_wr_o.idx = cnt_q;
      att_wr_o.ppn = ppn_full[`HACD_LPN_W-1:0];
      // idle passes the cpu through only when bypassed
      cpu_ovrd_o.allow_access = ((state_q == IDLE) && hawk_inactive_i) ||
                                (state_q == ACTIVE);
      cpu_ovrd_o.translate    = (state_q == ACTIVE) && !hawk_inactive_i;
   end

   assign list_req_o  = list_req_q;
   assign init_done_o = (state_q == ACTIVE);

   // writer must have dropped ack before a new request
   a_req_after_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $rose(list_req_o) |-> !list_ack_i);

endmodule

`default_nettype wire

// ==== src/hawk_att.sv ====
/*
 * Attribute translation table, one physical page per logical page.
 * Entries have no reset and are valid only after the control unit fills them.
 */
`timescale 1ns/100ps
`default_nettype none

`include "hacd_cfg.svh"

module hawk_att
   import hacd_pkg::*;
(
   input  wire                         clk_i,
   input  wire                         arst_n_i,
   input  wire att_wr_t                att_wr_i,    // fill port
   input  wire [`HACD_LPN_W-1:0]       lkup_lpn_i,  // from stall stage
   output logic [`HACD_LPN_W-1:0]      lkup_ppn_o
);

   logic [`HACD_LPN_W-1:0] ppn_q [`HACD_NUM_PAGES];   // table storage

   // one entry per cycle
   always_ff @(posedge clk_i) begin
      if (att_wr_i.en) begin
         ppn_q[att_wr_i.idx] <= att_wr_i.ppn;
      end
   end

   assign lkup_ppn_o = ppn_q[lkup_lpn_i];   // async read

endmodule

`default_nettype wire

// ==== src/hawk_cpu_stall.sv ====
/*
 * Holds one CPU request, removes the board offset and translates the page.
 * The ATT lookup is combinational, in the accept cycle.
 * At most one request is accepted every two cycles.
 */
`timescale 1ns/100ps
`default_nettype none

`include "hacd_cfg.svh"

module hawk_cpu_stall
   import hacd_pkg::*;
(
   input  wire                    clk_i,
   input  wire                    arst_n_i,
   input  wire                    uart_boot_en_i,
   input  wire cpu_ovrd_t         cpu_ovrd_i,
   // cpu request
   input  wire mem_req_t          cpu_req_i,
   input  wire                    cpu_req_valid_i,
   output logic                   cpu_req_ready_o,
   // att lookup
   output logic [`HACD_LPN_W-1:0] lkup_lpn_o,
   input  wire [`HACD_LPN_W-1:0]  lkup_ppn_i,
   // towards mux
   output mem_req_t               out_req_o,
   output logic                   out_valid_o,
   input  wire                    out_ready_i
);

   logic [`HACD_ADDR_W-1:0] addr_nb;     // offset removed
   mem_req_t                xlat_req;
   mem_req_t                held_q;      // payload only
   logic                    held_vld_q;
   logic                    take;

   //////////////////////////////
   // address path
   //////////////////////////////

   assign addr_nb    = uart_boot_en_i ? cpu_req_i.addr
                                      : cpu_req_i.addr - `HACD_DRAM_BASE;
   assign lkup_lpn_o = addr_nb[`HACD_PAGE_SHIFT +: `HACD_LPN_W];

   always_comb begin
      xlat_req      = cpu_req_i;
      xlat_req.addr = addr_nb;
      if (cpu_ovrd_i.translate) begin
         // swap page index, keep offset and upper bits
         xlat_req.addr[`HACD_PAGE_SHIFT +: `HACD_LPN_W] = lkup_ppn_i;
      end
   end

   //////////////////////////////
   // hold stage
   //////////////////////////////

   assign cpu_req_ready_o = !held_vld_q && cpu_ovrd_i.allow_access;
   assign take            = cpu_req_valid_i && cpu_req_ready_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         held_vld_q <= 1'b0;
      end else if (take) begin
         held_vld_q <= 1'b1;
      end else if (out_ready_i) begin
         held_vld_q <= 1'b0;             // handed to mux
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) begin
         held_q <= xlat_req;
      end
   end

   assign out_req_o   = held_q;
   assign out_valid_o = held_vld_q;

   // request may not change or drop under back-pressure
   a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_req_o));

endmodule

`default_nettype wire

// ==== src/hawk_list_writer.sv ====
/*
 * Writes the initial free list, one word per page, then acknowledges.
 * Entry i holds i+1 as next pointer; the last entry holds the null marker.
 * Write responses carry no data and are always accepted.
 */
`timescale 1ns/100ps
`default_nettype none

`include "hacd_cfg.svh"

module hawk_list_writer
   import hacd_pkg::*;
(
   input  wire      clk_i,
   input  wire      arst_n_i,
   input  wire      list_req_i,   // four-phase with ctrl unit
   output logic     list_ack_o,
   output mem_req_t wr_req_o,
   output logic     wr_valid_o,
   input  wire      wr_ready_i,
   input  wire      wr_done_i     // write response seen
);

   typedef enum logic [1:0] {LW_IDLE, LW_WRITE, LW_WAIT, LW_ACK} lw_state_e;

   lw_state_e               state_q;
   logic [`HACD_LPN_W-1:0]  idx_q;      // list entry
   logic [`HACD_ADDR_W-1:0] idx_ext;
   logic                    last_idx;

   assign idx_ext  = {{(`HACD_ADDR_W-`HACD_LPN_W){1'b0}}, idx_q};
   assign last_idx = (idx_ext == `HACD_NUM_PAGES - 1);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= LW_IDLE;
         idx_q   <= '0;
      end else begin
         case (state_q)
            LW_IDLE: if (list_req_i) begin
               state_q <= LW_WRITE;
               idx_q   <= '0;
            end
            LW_WRITE: if (wr_ready_i) state_q <= LW_WAIT;   // accepted
            LW_WAIT: if (wr_done_i) begin
               if (last_idx) begin
                  state_q <= LW_ACK;     // ack next cycle
               end else begin
                  state_q <= LW_WRITE;
                  idx_q   <= idx_q + 1'b1;
               end
            end
            default: if (!list_req_i) state_q <= LW_IDLE;   // drop ack
         endcase
      end
   end

   always_comb begin
      wr_req_o.wr    = 1'b1;
      wr_req_o.addr  = `HACD_LIST_BASE + (idx_ext << 2);   // word per entry
      wr_req_o.wdata = last_idx ? `HACD_LIST_NULL : idx_ext + 32'd1;
   end

   assign wr_valid_o = (state_q == LW_WRITE);
   assign list_ack_o = (state_q == LW_ACK);

endmodule

`default_nettype wire

// ==== src/hawk_mem_mux.sv ====
/*
 * Shares the MC port between the core master and the CPU path.
 * One transaction at a time; the core master wins a tie.
 * The MC must not return a response in the cycle its request is taken.
 */
`timescale 1ns/100ps
`default_nettype none

module hawk_mem_mux
   import hacd_pkg::*;
(
   input  wire           clk_i,
   input  wire           arst_n_i,
   // core master
   input  wire mem_req_t hawk_req_i,
   input  wire           hawk_valid_i,
   output logic          hawk_ready_o,
   output logic          hawk_done_o,     // response pulse
   // cpu path
   input  wire mem_req_t cpu_req_i,
   input  wire           cpu_valid_i,
   output logic          cpu_ready_o,
   output mem_rsp_t      cpu_rsp_o,
   output logic          cpu_rsp_valid_o,
   input  wire           cpu_rsp_ready_i,
   // memory controller
   output mem_req_t      mc_req_o,
   output logic          mc_valid_o,
   input  wire           mc_ready_i,
   input  wire mem_rsp_t mc_rsp_i,
   input  wire           mc_rsp_valid_i,
   output logic          mc_rsp_ready_o
);

   logic busy_q;        // request taken, response pending
   logic lock_q;        // offered but stalled, keep selection
   logic own_hawk_q;    // owner of current slot
   logic sel_hawk;
   logic req_xfer, rsp_xfer;

   //////////////////////////////
   // request steering
   //////////////////////////////

   assign sel_hawk     = lock_q ? own_hawk_q : hawk_valid_i;   // priority to core
   assign mc_req_o     = sel_hawk ? hawk_req_i : cpu_req_i;
   assign mc_valid_o   = !busy_q && (sel_hawk ? hawk_valid_i : cpu_valid_i);
   assign hawk_ready_o = !busy_q && sel_hawk && mc_ready_i;
   assign cpu_ready_o  = !busy_q && !sel_hawk && mc_ready_i;
   assign req_xfer     = mc_valid_o && mc_ready_i;

   //////////////////////////////
   // response routing
   //////////////////////////////

   assign cpu_rsp_o       = mc_rsp_i;
   assign cpu_rsp_valid_o = busy_q && !own_hawk_q && mc_rsp_valid_i;
   assign hawk_done_o     = busy_q && own_hawk_q && mc_rsp_valid_i;
   assign mc_rsp_ready_o  = busy_q && (own_hawk_q || cpu_rsp_ready_i);
   assign rsp_xfer        = mc_rsp_valid_i && mc_rsp_ready_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q     <= 1'b0;
         lock_q     <= 1'b0;
         own_hawk_q <= 1'b0;
      end else if (req_xfer) begin
         busy_q     <= 1'b1;          // grant held till response
         lock_q     <= 1'b0;
         own_hawk_q <= sel_hawk;
      end else if (mc_valid_o) begin
         lock_q     <= 1'b1;          // mc stalled us
         own_hawk_q <= sel_hawk;
      end else if (rsp_xfer) begin
         busy_q     <= 1'b0;
      end
   end

   // mc may only answer a request it took
   a_no_stray_rsp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !busy_q |-> !mc_rsp_valid_i);

endmodule

`default_nettype wire

// ==== src/hacd_core.sv ====
/*
 * Memory core between one CPU port and one memory-controller port.
 * hawk_inactive_i may only change while no transaction is in flight.
 * One transaction is outstanding on the MC port at a time.
 */
`timescale 1ns/100ps
`default_nettype none

module hacd_core
   import hacd_pkg::*;
(
   input  wire           clk_i,
   input  wire           arst_n_i,
   input  wire           uart_boot_en_i,   // keep board offset
   input  wire           hawk_inactive_i,  // bypass, no init
   // cpu side
   input  wire mem_req_t cpu_req_i,
   input  wire           cpu_req_valid_i,
   output logic          cpu_req_ready_o,
   output mem_rsp_t      cpu_rsp_o,
   output logic          cpu_rsp_valid_o,
   input  wire           cpu_rsp_ready_i,
   // memory controller side
   output mem_req_t      mc_req_o,
   output logic          mc_req_valid_o,
   input  wire           mc_req_ready_i,
   input  wire mem_rsp_t mc_rsp_i,
   input  wire           mc_rsp_valid_i,
   output logic          mc_rsp_ready_o,
   output logic          init_done_o
);

   att_wr_t                att_wr;      // ctrl -> att
   cpu_ovrd_t              cpu_ovrd;    // ctrl -> stall
   logic                   list_req, list_ack;
   logic [`HACD_LPN_W-1:0] lkup_lpn, lkup_ppn;
   mem_req_t               stall_req, lw_req;
   logic                   stall_valid, stall_ready;
   logic                   lw_valid, lw_ready, lw_done;

   //////////////////////////////
   // control and table
   //////////////////////////////

   hawk_ctrl_unit u_hawk_cu (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .hawk_inactive_i (hawk_inactive_i),
      .list_ack_i      (list_ack),
      .list_req_o      (list_req),
      .att_wr_o        (att_wr),
      .cpu_ovrd_o      (cpu_ovrd),
      .init_done_o     (init_done_o)
   );

   hawk_att u_hawk_att (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .att_wr_i   (att_wr),
      .lkup_lpn_i (lkup_lpn),
      .lkup_ppn_o (lkup_ppn)
   );

   //////////////////////////////
   // request sources
   //////////////////////////////

   hawk_cpu_stall u_hawk_cpu_stall (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .uart_boot_en_i  (uart_boot_en_i),
      .cpu_ovrd_i      (cpu_ovrd),
      .cpu_req_i       (cpu_req_i),
      .cpu_req_valid_i (cpu_req_valid_i),
      .cpu_req_ready_o (cpu_req_ready_o),
      .lkup_lpn_o      (lkup_lpn),
      .lkup_ppn_i      (lkup_ppn),
      .out_req_o       (stall_req),
      .out_valid_o     (stall_valid),
      .out_ready_i     (stall_ready)
   );

   hawk_list_writer u_hawk_list_writer (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .list_req_i (list_req),
      .list_ack_o (list_ack),
      .wr_req_o   (lw_req),
      .wr_valid_o (lw_valid),
      .wr_ready_i (lw_ready),
      .wr_done_i  (lw_done)
   );

   hawk_mem_mux u_hawk_mem_mux (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .hawk_req_i      (lw_req),
      .hawk_valid_i    (lw_valid),
      .hawk_ready_o    (lw_ready),
      .hawk_done_o     (lw_done),
      .cpu_req_i       (stall_req),
      .cpu_valid_i     (stall_valid),
      .cpu_ready_o     (stall_ready),
      .cpu_rsp_o       (cpu_rsp_o),
      .cpu_rsp_valid_o (cpu_rsp_valid_o),
      .cpu_rsp_ready_i (cpu_rsp_ready_i),
      .mc_req_o        (mc_req_o),
      .mc_valid_o      (mc_req_valid_o),
      .mc_ready_i      (mc_req_ready_i),
      .mc_rsp_i        (mc_rsp_i),
      .mc_rsp_valid_i  (mc_rsp_valid_i),
      .mc_rsp_ready_o  (mc_rsp_ready_o)
   );

endmodule

`default_nettype wire

// ==== verification/tb_clkgen.sv ====
/*
 * Clock and reset for the memory core testbench.
 * 8 ns period, reset held low for 8 cycles after start and after each
 * rising edge of rst_req_i, released 1 ns after a rising clock edge.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
   input  wire  rst_req_i,   // pulse to reset again
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #4 clk_o = ~clk_o;            // 8 ns period
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (8) @(posedge clk_o);
      #1 arst_n_o = 1'b1;
      forever begin
         @(posedge rst_req_i);
         arst_n_o = 1'b0;                   // async assert
         repeat (8) @(posedge clk_o);
         #1 arst_n_o = 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== verification/tb_hacd_core.sv ====
/*
 * Directed testbench for the memory core with a sparse MC model.
 * Inputs change 1 ns after the rising edge, outputs are sampled on the
 * falling edge. The MC model answers one request at a time, with random
 * back-pressure and delay from a Galois LFSR.
 */
`timescale 1ns/100ps
`default_nettype none

`include "hacd_cfg.svh"

module tb_hacd_core
   import hacd_pkg::*;
();

   localparam int WAIT_LIMIT = 2000;              // cycles per wait loop

   logic     clk, arst_n, rst_req;
   logic     uart_boot_en, hawk_inactive;
   mem_req_t cpu_req, mc_req;
   mem_rsp_t cpu_rsp, mc_rsp;
   logic     cpu_req_valid, cpu_req_ready, cpu_rsp_valid, cpu_rsp_ready;
   logic     mc_req_valid, mc_req_ready, mc_rsp_valid, mc_rsp_ready;
   logic     init_done;

   logic [15:0] lfsr_q = 16'd41558;               // seed
   mem_req_t    log_q[$];                         // requests seen by mc
   logic [31:0] mc_mem [logic [31:0]];            // mc storage
   logic [31:0] ref_mem [logic [31:0]];           // expected storage

   tb_clkgen i_clkgen (.rst_req_i(rst_req), .clk_o(clk), .arst_n_o(arst_n));

   hacd_core i_dut (
      .clk_i           (clk),
      .arst_n_i        (arst_n),
      .uart_boot_en_i  (uart_boot_en),
      .hawk_inactive_i (hawk_inactive),
      .cpu_req_i       (cpu_req),
      .cpu_req_valid_i (cpu_req_valid),
      .cpu_req_ready_o (cpu_req_ready),
      .cpu_rsp_o       (cpu_rsp),
      .cpu_rsp_valid_o (cpu_rsp_valid),
      .cpu_rsp_ready_i (cpu_rsp_ready),
      .mc_req_o        (mc_req),
      .mc_req_valid_o  (mc_req_valid),
      .mc_req_ready_i  (mc_req_ready),
      .mc_rsp_i        (mc_rsp),
      .mc_rsp_valid_i  (mc_rsp_valid),
      .mc_rsp_ready_o  (mc_rsp_ready),
      .init_done_o     (init_done)
   );

   //////////////////////////////
   // helpers
   //////////////////////////////

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // galois, taps 16 14 13 11
   endfunction

   function logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_q = lfsr_step(lfsr_q);               // one step per bit
         v      = {v[6:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // unwritten words read back a pattern of the whole address
   function automatic logic [31:0] fill_word(input logic [31:0] a);
      return {a[15:0], a[31:16]} ^ 32'h5A5A_A5A5;
   endfunction

   // physical address the mc should see for a cpu address
   function automatic logic [31:0] expect_addr(input logic [31:0] cpu_addr,
                                               input logic uart, input logic xlat);
      logic [31:0]            a;
      logic [`HACD_LPN_W-1:0] lpn;
      logic [31:0]            ppn;
      a   = uart ? cpu_addr : cpu_addr - `HACD_DRAM_BASE;
      lpn = a[`HACD_PAGE_SHIFT +: `HACD_LPN_W];
      ppn = `HACD_NUM_PAGES - 1 - {{(32-`HACD_LPN_W){1'b0}}, lpn};   // reversed map
      if (xlat) begin
         a[`HACD_PAGE_SHIFT +: `HACD_LPN_W] = ppn[`HACD_LPN_W-1:0];
      end
      return a;
   endfunction

   task fail_stop;
      $display("Checks failed");
      $fatal(1);
   endtask

   task report_error(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      fail_stop();
   endtask

   task check_req(input mem_req_t got, input mem_req_t exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s, got wr=%0b addr=%h data=%h, exp wr=%0b addr=%h data=%h",
                  $time, what, got.wr, got.addr, got.wdata, exp.wr, exp.addr, exp.wdata);
         fail_stop();
      end
   endtask

   task check_rsp(input mem_rsp_t got, input mem_rsp_t exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s, got rdata=%h err=%0b, exp rdata=%h err=%0b",
                  $time, what, got.rdata, got.err, exp.rdata, exp.err);
         fail_stop();
      end
   endtask

   //////////////////////////////
   // mc model
   //////////////////////////////

   initial begin : mc_model
      int       st;                                // 0 idle, 1 delay, 2 respond
      int       delay;
      logic     rdy_n;                             // ready for next cycle
      mem_req_t r;
      mem_rsp_t rsp_d;
      st    = 0;
      delay = 0;
      rdy_n = 1'b0;
      rsp_d = '0;
      mc_req_ready = 1'b0;
      mc_rsp_valid = 1'b0;
      mc_rsp       = '0;
      forever begin
         @(negedge clk);
         if (!arst_n) begin
            st = 0;
         end else if (st == 0) begin
            if (mc_req_valid && mc_req_ready) begin
               r = mc_req;
               log_q.push_back(r);
               rsp_d.err   = 1'b0;
               rsp_d.rdata = '0;                   // writes return zero
               if (r.wr) mc_mem[r.addr] = r.wdata;
               else rsp_d.rdata = mc_mem.exists(r.addr) ? mc_mem[r.addr] : fill_word(r.addr);
               delay = int'(rand_bits(2));
               st    = 1;
            end
         end else if (st == 1) begin
            if (delay == 0) st = 2;
            else delay--;
         end else if (mc_rsp_ready) begin
            st = 0;                                // response taken
         end
         rdy_n = (st == 0) && arst_n && (rand_bits(2) != 8'd0);   // random back-pressure
         @(posedge clk);
         #1;
         mc_rsp_valid = (st == 2);
         mc_rsp       = rsp_d;
         mc_req_ready = rdy_n;
      end
   end

   //////////////////////////////
   // cpu side tasks
   //////////////////////////////

   task cpu_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                   input logic rsp_bp, output mem_rsp_t rsp);
      int   t;
      logic done;
      @(posedge clk);
      #1;
      cpu_req.wr    = wr;
      cpu_req.addr  = addr;
      cpu_req.wdata = wdata;
      cpu_req_valid = 1'b1;
      t    = 0;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (cpu_req_ready) begin
            done = 1'b1;
         end else begin
            t = t + 1;
            if (t > WAIT_LIMIT) report_error("CPU request was never accepted");
         end
      end
      @(posedge clk);
      #1;
      cpu_req_valid = 1'b0;
      cpu_rsp_ready = rsp_bp ? (rand_bits(1) != 8'd0) : 1'b1;
      t    = 0;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (cpu_rsp_valid && cpu_rsp_ready) begin
            rsp  = cpu_rsp;
            done = 1'b1;
         end else begin
            t = t + 1;
            if (t > WAIT_LIMIT) report_error("no CPU response arrived");
            @(posedge clk);
            #1;
            cpu_rsp_ready = rsp_bp ? (rand_bits(1) != 8'd0) : 1'b1;   // random back-pressure
         end
      end
      @(posedge clk);
      #1;
      cpu_rsp_ready = 1'b0;
   endtask

   // one access, checked against the reference memory and the mc log
   task access_and_check(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic xlat, input logic rsp_bp);
      logic [31:0] phys;
      mem_req_t    exp_req;
      mem_rsp_t    exp_rsp, got;
      phys          = expect_addr(addr, uart_boot_en, xlat);
      exp_req.wr    = wr;
      exp_req.addr  = phys;
      exp_req.wdata = wdata;
      exp_rsp.err   = 1'b0;
      exp_rsp.rdata = wr ? 32'd0 : (ref_mem.exists(phys) ? ref_mem[phys] : fill_word(phys));
      cpu_access(wr, addr, wdata, rsp_bp, got);
      check_rsp(got, exp_rsp, wr ? "write response" : "read response");
      if (log_q.size() != 1) report_error("expected exactly one MC request per CPU access");
      check_req(log_q.pop_front(), exp_req, "MC request");
      if (wr) ref_mem[phys] = wdata;
   endtask

   task wait_reset_release;
      int t;
      t = 0;
      while (!arst_n) begin
         @(posedge clk);
         t = t + 1;
         if (t > WAIT_LIMIT) report_error("reset was never released");
      end
   endtask

   task apply_reset;
      @(posedge clk);
      #1 rst_req = 1'b1;
      @(posedge clk);
      #1 rst_req = 1'b0;
      log_q.delete();
      wait_reset_release();
   endtask

   //////////////////////////////
   // directed tests
   //////////////////////////////

   task test_init_sequence;
      int       t;
      logic     done;
      mem_req_t exp;
      t    = 0;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (init_done) done = 1'b1;
         else begin
            if (cpu_req_ready) report_error("CPU port was ready before init finished");
            t = t + 1;
            if (t > WAIT_LIMIT) report_error("initialisation never finished");
         end
      end
      if (log_q.size() != `HACD_NUM_PAGES) report_error("wrong number of free-list writes");
      for (int i = 0; i < `HACD_NUM_PAGES; i++) begin
         exp.wr    = 1'b1;
         exp.addr  = `HACD_LIST_BASE + 32'(i * 4);
         exp.wdata = (i == `HACD_NUM_PAGES - 1) ? `HACD_LIST_NULL : 32'(i + 1);
         check_req(log_q[i], exp, "free-list write");
      end
      log_q.delete();
   endtask

   task test_translated_rw(input int x);
      logic [31:0] addr;
      addr = `HACD_DRAM_BASE + 32'(x << `HACD_PAGE_SHIFT) + 32'h124;
      access_and_check(1'b1, addr, 32'hD00D_0000 + 32'(x), 1'b1, 1'b0);
      access_and_check(1'b0, addr, 32'd0, 1'b1, 1'b0);       // read back
   endtask

   task test_uart_boot;
      @(posedge clk);
      #1 uart_boot_en = 1'b1;                     // offset kept
      access_and_check(1'b1, 32'h0001_2008, 32'hCAFE_0012, 1'b1, 1'b0);
      access_and_check(1'b0, 32'h0001_2008, 32'd0, 1'b1, 1'b0);
      @(posedge clk);
      #1 uart_boot_en = 1'b0;
   endtask

   task test_random_traffic(input int n);
      logic [31:0] addr, data;
      logic [7:0]  pg, wd;
      logic        wr;
      for (int i = 0; i < n; i++) begin
         wr   = (rand_bits(1) != 8'd0);
         pg   = rand_bits(4);                     // logical page
         wd   = rand_bits(8);                     // word in page
         addr = `HACD_DRAM_BASE + {16'd0, pg[3:0], 2'b00, wd, 2'b00};
         data = {rand_bits(8), rand_bits(8), rand_bits(8), rand_bits(8)};
         access_and_check(wr, addr, data, 1'b1, 1'b1);
      end
   endtask

   task test_inactive_bypass;
      @(posedge clk);
      #1 hawk_inactive = 1'b1;
      apply_reset();
      repeat (40) begin                           // observation window
         @(negedge clk);
         if (init_done) report_error("init_done rose while the core was inactive");
         if (log_q.size() != 0) report_error("MC saw a write while the core was inactive");
      end
      access_and_check(1'b1, 32'h8000_3010, 32'h1234_5678, 1'b0, 1'b0);
      access_and_check(1'b0, 32'h8000_3010, 32'd0, 1'b0, 1'b0);
      @(posedge clk);
      #1 hawk_inactive = 1'b0;                    // start init now
      test_init_sequence();
      test_translated_rw(7);
   endtask

   initial begin
      rst_req       = 1'b0;
      uart_boot_en  = 1'b0;
      hawk_inactive = 1'b0;
      cpu_req       = '0;
      cpu_req_valid = 1'b0;
      cpu_rsp_ready = 1'b0;
      wait_reset_release();
      test_init_sequence();
      test_translated_rw(3);
      test_translated_rw(12);
      test_uart_boot();
      test_random_traffic(24);
      test_inactive_bypass();
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/hacd_pkg.sv
src/hawk_ctrl_unit.sv
src/hawk_att.sv
src/hawk_cpu_stall.sv
src/hawk_list_writer.sv
src/hawk_mem_mux.sv
src/hacd_core.sv
verification/tb_clkgen.sv
verification/tb_hacd_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory core testbench with Verilator.
# Exit status is nonzero when the log reports a failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
   --top-module tb_hacd_core -o sim_tb > build.log 2>&1 \
   || { cat build.log; echo "build error"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || { echo "simulation ended early"; exit 1; }
exit 0
